//--- mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

`define MIPS_DATA_W      32
`define MIPS_REG_ADDR_W  5
`define MIPS_NUM_REGS    32
`define MIPS_RESET_PC    32'h0000_0000

// Primary opcodes, bits 31:26
`define MIPS_OP_RTYPE    6'b000000
`define MIPS_OP_J        6'b000010
`define MIPS_OP_BEQ      6'b000100
`define MIPS_OP_BNE      6'b000101
`define MIPS_OP_ADDI     6'b001000
`define MIPS_OP_ORI      6'b001101
`define MIPS_OP_LW       6'b100011
`define MIPS_OP_SW       6'b101011

// R-type function codes, bits 5:0
`define MIPS_FN_ADDU     6'b100001
`define MIPS_FN_SUBU     6'b100011
`define MIPS_FN_AND      6'b100100
`define MIPS_FN_OR       6'b100101
`define MIPS_FN_SLT      6'b101010

`endif

//--- mips_pkg.sv
`include "mips_macros.svh"

package mips_pkg;

    typedef logic [`MIPS_DATA_W-1:0] word_t;
    typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

    // Operand source, nearer stage wins
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_to_reg;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        logic    beq;
        logic    bne;
        logic    jump;
        alu_op_e alu_op;
    } ctrl_t;

endpackage

//--- pc_counter.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module pc_counter (
    input  logic            clk,
    input  logic            rst,
    input  logic            pc_write_i,
    input  logic            load_i,
    input  mips_pkg::word_t target_i,
    output mips_pkg::word_t pc_o,
    output mips_pkg::word_t pc_plus4_o
);
    import mips_pkg::*;

    word_t pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= `MIPS_RESET_PC;
        end else if (pc_write_i) begin
            pc_q <= load_i ? target_i : pc_plus4_o;
        end
    end

    assign pc_o       = pc_q;
    assign pc_plus4_o = pc_q + word_t'(4);

endmodule

//--- stall_ctrl.sv
`timescale 1ns/1ps

module stall_ctrl (
    input  logic icache_stall_i,
    input  logic dcache_stall_i,
    input  logic load_use_i,
    input  logic branch_taken_i,
    input  logic jump_i,
    output logic pc_write_o,
    output logic pc_load_o,
    output logic id_write_o,
    output logic id_flush_o,
    output logic ex_bubble_o,
    output logic back_write_o
);
    logic freeze;

    // Any cache miss holds the whole pipe
    assign freeze = icache_stall_i | dcache_stall_i;

    assign back_write_o = !freeze;

    // Load-use keeps fetch and decode, sends a nop forward
    assign ex_bubble_o = !freeze && load_use_i;
    assign pc_write_o  = !freeze && !load_use_i;
    assign id_write_o  = !freeze && !load_use_i;

    // Branch compare is only trusted once decode is free to move
    assign id_flush_o = pc_write_o && branch_taken_i;

    // Only matters when pc_write_o is high
    assign pc_load_o = branch_taken_i || jump_i;

endmodule

//--- mips_decoder.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_decoder (
    input  mips_pkg::word_t     inst_i,
    output mips_pkg::ctrl_t     ctrl_o,
    output mips_pkg::reg_addr_t rs_o,
    output mips_pkg::reg_addr_t rt_o,
    output mips_pkg::reg_addr_t rd_o,
    output mips_pkg::word_t     imm_o
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = inst_i[31:26];
    assign funct  = inst_i[5:0];
    assign rs_o   = inst_i[25:21];
    assign rt_o   = inst_i[20:16];

    // I-type results land in rt
    assign rd_o = (opcode == `MIPS_OP_RTYPE) ? inst_i[15:11] : inst_i[20:16];

    assign imm_o = (opcode == `MIPS_OP_ORI) ?
        {{(`MIPS_DATA_W-16){1'b0}}, inst_i[15:0]} :
        {{(`MIPS_DATA_W-16){inst_i[15]}}, inst_i[15:0]};

    always_comb begin
        ctrl_o = '0;
        case (opcode)
            `MIPS_OP_RTYPE: begin
                ctrl_o.reg_write = 1'b1;
                case (funct)
                    `MIPS_FN_ADDU: ctrl_o.alu_op = ALU_ADD;
                    `MIPS_FN_SUBU: ctrl_o.alu_op = ALU_SUB;
                    `MIPS_FN_AND:  ctrl_o.alu_op = ALU_AND;
                    `MIPS_FN_OR:   ctrl_o.alu_op = ALU_OR;
                    `MIPS_FN_SLT:  ctrl_o.alu_op = ALU_SLT;
                    // unsupported funct behaves as nop
                    default:       ctrl_o.reg_write = 1'b0;
                endcase
            end
            `MIPS_OP_ADDI: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
            end
            `MIPS_OP_ORI: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.alu_op      = ALU_OR;
            end
            `MIPS_OP_LW: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.mem_to_reg  = 1'b1;
                ctrl_o.mem_read    = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
            end
            `MIPS_OP_SW: begin
                ctrl_o.mem_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
            end
            `MIPS_OP_BEQ: ctrl_o.beq  = 1'b1;
            `MIPS_OP_BNE: ctrl_o.bne  = 1'b1;
            `MIPS_OP_J:   ctrl_o.jump = 1'b1;
            default: ctrl_o = '0;
        endcase
    end

endmodule

//--- reg_file.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst,
    input  logic                we_i,
    input  mips_pkg::reg_addr_t waddr_i,
    input  mips_pkg::reg_addr_t raddr_a_i,
    input  mips_pkg::reg_addr_t raddr_b_i,
    input  mips_pkg::word_t     wdata_i,
    output mips_pkg::word_t     rdata_a_o,
    output mips_pkg::word_t     rdata_b_o
);
    import mips_pkg::*;

    // r0 has no storage
    word_t regs [1:`MIPS_NUM_REGS-1];

    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        // Writeback in the same cycle shows through
        if (we_i && addr == waddr_i) begin
            return wdata_i;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        rdata_a_o = read_port(raddr_a_i);
        rdata_b_o = read_port(raddr_b_i);
    end

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
    input  mips_pkg::alu_op_e op_i,
    input  mips_pkg::word_t   a_i,
    input  mips_pkg::word_t   b_i,
    output mips_pkg::word_t   res_o
);
    import mips_pkg::*;

    always_comb begin
        case (op_i)
            ALU_ADD: res_o = a_i + b_i;
            ALU_SUB: res_o = a_i - b_i;
            ALU_AND: res_o = a_i & b_i;
            ALU_OR:  res_o = a_i | b_i;
            // signed compare
            ALU_SLT: res_o = word_t'($signed(a_i) < $signed(b_i));
            default: res_o = '0;
        endcase
    end

endmodule

//--- forward_unit.sv
`timescale 1ns/1ps

module forward_unit (
    input  mips_pkg::reg_addr_t rs_i,
    input  mips_pkg::reg_addr_t rt_i,
    input  mips_pkg::reg_addr_t mem_rd_i,
    input  mips_pkg::reg_addr_t wb_rd_i,
    input  logic                mem_reg_write_i,
    input  logic                wb_reg_write_i,
    output mips_pkg::fwd_sel_e  fwd_a_o,
    output mips_pkg::fwd_sel_e  fwd_b_o
);
    import mips_pkg::*;

    // Near stage holds the youngest value, so it is checked first
    function automatic fwd_sel_e pick(input reg_addr_t src);
        if (mem_reg_write_i && mem_rd_i != '0 && mem_rd_i == src) begin
            return FWD_MEM;
        end
        if (wb_reg_write_i && wb_rd_i != '0 && wb_rd_i == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        fwd_a_o = pick(rs_i);
        fwd_b_o = pick(rt_i);
    end

endmodule

//--- mips_pipeline.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_pipeline (
    input  logic                      clk,
    input  logic                      rst,
    output logic [`MIPS_DATA_W-3:0]   icache_addr_o,
    input  mips_pkg::word_t           icache_rdata_i,
    input  logic                      icache_stall_i,
    output logic                      dcache_ren_o,
    output logic                      dcache_wen_o,
    output logic [`MIPS_DATA_W-3:0]   dcache_addr_o,
    output mips_pkg::word_t           dcache_wdata_o,
    input  mips_pkg::word_t           dcache_rdata_i,
    input  logic                      dcache_stall_i
);
    import mips_pkg::*;

    word_t     if_pc, if_pc_plus4, if_target, jump_target;
    logic      if_jump;
    word_t     id_inst, id_pc_plus4;
    ctrl_t     id_ctrl;
    reg_addr_t id_rs, id_rt, id_rd;
    word_t     id_imm, id_rs_reg, id_rt_reg, id_rs_val, id_rt_val, branch_target;
    fwd_sel_e  id_fwd_a, id_fwd_b;
    logic      branch_taken, id_reads_rs, id_reads_rt;
    logic      ex_load_hit, mem_load_hit, load_use;
    ctrl_t     ex_ctrl;
    reg_addr_t ex_rs, ex_rt, ex_rd;
    word_t     ex_rs_data, ex_rt_data, ex_imm;
    word_t     ex_a, ex_b, ex_rt_fwd, ex_alu_res;
    fwd_sel_e  ex_fwd_a, ex_fwd_b;
    ctrl_t     mem_ctrl;
    reg_addr_t mem_rd;
    word_t     mem_alu_res, mem_store_data;
    logic      mem_store_done;
    ctrl_t     wb_ctrl;
    reg_addr_t wb_rd;
    word_t     wb_alu_res, wb_load_data, wb_data;
    logic      pc_write, pc_load, id_write, id_flush, ex_bubble, back_write;

    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
                                      input word_t near_val, input word_t far_val);
        case (sel)
            FWD_MEM: return near_val;
            FWD_WB:  return far_val;
            default: return reg_val;
        endcase
    endfunction

    // Fetch, jumps redirect here with no lost slot
    assign icache_addr_o = if_pc[`MIPS_DATA_W-1:2];
    assign if_jump       = icache_rdata_i[31:26] == `MIPS_OP_J;
    assign jump_target   = {if_pc_plus4[31:28], icache_rdata_i[25:0], 2'b00};
    assign if_target     = branch_taken ? branch_target : jump_target;

    pc_counter u_pc (
        .clk        (clk),
        .rst        (rst),
        .pc_write_i (pc_write),
        .load_i     (pc_load),
        .target_i   (if_target),
        .pc_o       (if_pc),
        .pc_plus4_o (if_pc_plus4)
    );

    always_ff @(posedge clk) begin
        if (rst || id_flush) begin
            id_inst     <= '0;
            id_pc_plus4 <= '0;
        end else if (id_write) begin
            id_inst     <= icache_rdata_i;
            id_pc_plus4 <= if_pc_plus4;
        end
    end

    mips_decoder u_dec (
        .inst_i (id_inst),
        .ctrl_o (id_ctrl),
        .rs_o   (id_rs),
        .rt_o   (id_rt),
        .rd_o   (id_rd),
        .imm_o  (id_imm)
    );

    reg_file u_rf (
        .clk       (clk),
        .rst       (rst),
        .we_i      (wb_ctrl.reg_write),
        .waddr_i   (wb_rd),
        .raddr_a_i (id_rs),
        .raddr_b_i (id_rt),
        .wdata_i   (wb_data),
        .rdata_a_o (id_rs_reg),
        .rdata_b_o (id_rt_reg)
    );

    // Decode-side bypass, EX is near and MEM is far
    forward_unit u_fwd_id (
        .rs_i            (id_rs),
        .rt_i            (id_rt),
        .mem_rd_i        (ex_rd),
        .wb_rd_i         (mem_rd),
        .mem_reg_write_i (ex_ctrl.reg_write),
        .wb_reg_write_i  (mem_ctrl.reg_write),
        .fwd_a_o         (id_fwd_a),
        .fwd_b_o         (id_fwd_b)
    );

    assign id_rs_val     = fwd_mux(id_fwd_a, id_rs_reg, ex_alu_res, mem_alu_res);
    assign id_rt_val     = fwd_mux(id_fwd_b, id_rt_reg, ex_alu_res, mem_alu_res);
    assign branch_target = id_pc_plus4 + {id_imm[`MIPS_DATA_W-3:0], 2'b00};
    assign branch_taken  = (id_ctrl.beq && id_rs_val == id_rt_val) ||
                           (id_ctrl.bne && id_rs_val != id_rt_val);

    // Load results are not ready for forwarding until writeback
    assign id_reads_rs  = !id_ctrl.jump;
    assign id_reads_rt  = (!id_ctrl.alu_src_imm && !id_ctrl.jump) || id_ctrl.mem_write;
    assign ex_load_hit  = ex_ctrl.mem_read && ex_rd != '0 &&
                          ((id_reads_rs && id_rs == ex_rd) || (id_reads_rt && id_rt == ex_rd));
    assign mem_load_hit = (id_ctrl.beq || id_ctrl.bne) && mem_ctrl.mem_read &&
                          mem_rd != '0 && (id_rs == mem_rd || id_rt == mem_rd);
    assign load_use     = ex_load_hit || mem_load_hit;

    stall_ctrl u_stall (
        .icache_stall_i (icache_stall_i),
        .dcache_stall_i (dcache_stall_i),
        .load_use_i     (load_use),
        .branch_taken_i (branch_taken),
        .jump_i         (if_jump),
        .pc_write_o     (pc_write),
        .pc_load_o      (pc_load),
        .id_write_o     (id_write),
        .id_flush_o     (id_flush),
        .ex_bubble_o    (ex_bubble),
        .back_write_o   (back_write)
    );

    always_ff @(posedge clk) begin
        if (rst || ex_bubble) begin
            ex_ctrl    <= '0;
            ex_rs      <= '0;
            ex_rt      <= '0;
            ex_rd      <= '0;
            ex_rs_data <= '0;
            ex_rt_data <= '0;
            ex_imm     <= '0;
        end else if (back_write) begin
            ex_ctrl    <= id_ctrl;
            ex_rs      <= id_rs;
            ex_rt      <= id_rt;
            ex_rd      <= id_rd;
            ex_rs_data <= id_rs_val;
            ex_rt_data <= id_rt_val;
            ex_imm     <= id_imm;
        end
    end

    forward_unit u_fwd_ex (
        .rs_i            (ex_rs),
        .rt_i            (ex_rt),
        .mem_rd_i        (mem_rd),
        .wb_rd_i         (wb_rd),
        .mem_reg_write_i (mem_ctrl.reg_write),
        .wb_reg_write_i  (wb_ctrl.reg_write),
        .fwd_a_o         (ex_fwd_a),
        .fwd_b_o         (ex_fwd_b)
    );

    assign ex_a      = fwd_mux(ex_fwd_a, ex_rs_data, mem_alu_res, wb_data);
    assign ex_rt_fwd = fwd_mux(ex_fwd_b, ex_rt_data, mem_alu_res, wb_data);
    assign ex_b      = ex_ctrl.alu_src_imm ? ex_imm : ex_rt_fwd;

    alu u_alu (
        .op_i  (ex_ctrl.alu_op),
        .a_i   (ex_a),
        .b_i   (ex_b),
        .res_o (ex_alu_res)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_ctrl       <= '0;
            mem_rd         <= '0;
            mem_alu_res    <= '0;
            mem_store_data <= '0;
        end else if (back_write) begin
            mem_ctrl       <= ex_ctrl;
            mem_rd         <= ex_rd;
            mem_alu_res    <= ex_alu_res;
            mem_store_data <= ex_rt_fwd;
        end
    end

    // Store already taken by the data cache during an icache freeze
    always_ff @(posedge clk) begin
        if (rst || back_write) begin
            mem_store_done <= 1'b0;
        end else if (mem_ctrl.mem_write && !dcache_stall_i) begin
            mem_store_done <= 1'b1;
        end
    end

    // Request stays put while the data cache stalls
    assign dcache_ren_o   = mem_ctrl.mem_read;
    assign dcache_wen_o   = mem_ctrl.mem_write && !mem_store_done;
    assign dcache_addr_o  = mem_alu_res[`MIPS_DATA_W-1:2];
    assign dcache_wdata_o = mem_store_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ctrl      <= '0;
            wb_rd        <= '0;
            wb_alu_res   <= '0;
            wb_load_data <= '0;
        end else if (back_write) begin
            wb_ctrl      <= mem_ctrl;
            wb_rd        <= mem_rd;
            wb_alu_res   <= mem_alu_res;
            wb_load_data <= dcache_rdata_i;
        end
    end

    assign wb_data = wb_ctrl.mem_to_reg ? wb_load_data : wb_alu_res;

endmodule

//--- tb_cache_model.sv
`timescale 1ns/1ps

module tb_cache_model (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall_en_i,
    input  logic [29:0]     icache_addr_i,
    output mips_pkg::word_t icache_rdata_o,
    output logic            icache_stall_o,
    input  logic            dcache_ren_i,
    input  logic            dcache_wen_i,
    input  logic [29:0]     dcache_addr_i,
    input  mips_pkg::word_t dcache_wdata_i,
    output mips_pkg::word_t dcache_rdata_o,
    output logic            dcache_stall_o
);
    import mips_pkg::*;

    localparam int DEPTH = 256;
    localparam logic [31:0] SEED = 32'h8ec97a51;

    // imem is loaded by the testbench top
    word_t imem [DEPTH];
    word_t dmem [DEPTH];
    word_t log_addr [$];
    word_t log_data [$];
    logic [31:0] rnd;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        rnd = SEED;
        icache_stall_o = 1'b0;
        dcache_stall_o = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            dmem[i] = (word_t'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
        end
    end

    // All ones whenever the returned word is not valid
    assign icache_rdata_o = icache_stall_o ? '1 : imem[icache_addr_i[7:0]];
    // Loads and stores share one array
    assign dcache_rdata_o = (dcache_ren_i && !dcache_stall_o) ? dmem[dcache_addr_i[7:0]] : '1;

    always @(posedge clk) begin
        rnd <= xorshift32(rnd);
        // About one cycle in four on each side
        icache_stall_o <= stall_en_i && rnd[1:0] == 2'b00;
        dcache_stall_o <= stall_en_i && rnd[5:4] == 2'b00;
        if (rst) begin
            log_addr.delete();
            log_data.delete();
        end else if (dcache_wen_i && !dcache_stall_o) begin
            dmem[dcache_addr_i[7:0]] <= dcache_wdata_i;
            log_addr.push_back({dcache_addr_i, 2'b00});
            log_data.push_back(dcache_wdata_i);
        end
    end

endmodule

//--- tb_mips_pipeline.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module tb_mips_pipeline;
    import mips_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_ENTRIES  = 14;
    localparam int DRAIN_CYCLES = 30;
    localparam int IMEM_DEPTH   = 256;

    localparam int K_ADDU  = 0;
    localparam int K_SUBU  = 1;
    localparam int K_AND   = 2;
    localparam int K_OR    = 3;
    localparam int K_SLT   = 4;
    localparam int K_ADDI  = 5;
    localparam int K_ORI   = 6;
    localparam int K_LWUSE = 7;
    localparam int K_BEQ   = 8;
    localparam int K_BNE   = 9;
    localparam int K_J     = 10;

    logic        clk;
    logic        rst;
    logic        stall_en;
    logic [29:0] icache_addr;
    word_t       icache_rdata;
    logic        icache_stall;
    logic        dcache_ren;
    logic        dcache_wen;
    logic [29:0] dcache_addr;
    word_t       dcache_wdata;
    word_t       dcache_rdata;
    logic        dcache_stall;

    int          tab_kind [NUM_ENTRIES];
    logic [15:0] tab_a [NUM_ENTRIES];
    logic [15:0] tab_b [NUM_ENTRIES];
    word_t       tab_addr [NUM_ENTRIES];

    word_t prog [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    int    entry_first [NUM_ENTRIES];
    int    entry_count [NUM_ENTRIES];
    int    error_count;
    int    pass_count;
    int    fail_count;
    logic  timed_out;

    mips_pipeline dut0 (
        .clk            (clk),
        .rst            (rst),
        .icache_addr_o  (icache_addr),
        .icache_rdata_i (icache_rdata),
        .icache_stall_i (icache_stall),
        .dcache_ren_o   (dcache_ren),
        .dcache_wen_o   (dcache_wen),
        .dcache_addr_o  (dcache_addr),
        .dcache_wdata_o (dcache_wdata),
        .dcache_rdata_i (dcache_rdata),
        .dcache_stall_i (dcache_stall)
    );

    tb_cache_model cache0 (
        .clk            (clk),
        .rst            (rst),
        .stall_en_i     (stall_en),
        .icache_addr_i  (icache_addr),
        .icache_rdata_o (icache_rdata),
        .icache_stall_o (icache_stall),
        .dcache_ren_i   (dcache_ren),
        .dcache_wen_i   (dcache_wen),
        .dcache_addr_i  (dcache_addr),
        .dcache_wdata_i (dcache_wdata),
        .dcache_rdata_o (dcache_rdata),
        .dcache_stall_o (dcache_stall)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic word_t sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic word_t enc_r(input logic [5:0] fn, input int rs, input int rt,
                                    input int rd);
        return {`MIPS_OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input int rs, input int rt,
                                    input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic word_t enc_j(input word_t byte_target);
        return {`MIPS_OP_J, byte_target[27:2]};
    endfunction

    // Result of the middle instruction from the ISA rules
    function automatic word_t ref_value(input int kind, input logic [15:0] a,
                                        input logic [15:0] b);
        word_t x;
        word_t y;
        x = sext16(a);
        y = sext16(b);
        case (kind)
            K_ADDU:  return x + y;
            K_SUBU:  return x - y;
            K_AND:   return x & y;
            K_OR:    return x | y;
            K_SLT:   return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            K_ADDI:  return x + y;
            K_ORI:   return x | {16'h0000, b};
            default: return '0;
        endcase
    endfunction

    function automatic logic [5:0] funct_of(input int kind);
        case (kind)
            K_ADDU:  return `MIPS_FN_ADDU;
            K_SUBU:  return `MIPS_FN_SUBU;
            K_AND:   return `MIPS_FN_AND;
            K_OR:    return `MIPS_FN_OR;
            default: return `MIPS_FN_SLT;
        endcase
    endfunction

    function automatic string kind_name(input int kind);
        case (kind)
            K_ADDU:  return "addu";
            K_SUBU:  return "subu";
            K_AND:   return "and";
            K_OR:    return "or";
            K_SLT:   return "slt";
            K_ADDI:  return "addi";
            K_ORI:   return "ori";
            K_LWUSE: return "lw-use";
            K_BEQ:   return "beq";
            K_BNE:   return "bne";
            default: return "j";
        endcase
    endfunction

    task automatic set_entry(input int i, input int kind, input logic [15:0] a,
                             input logic [15:0] b, input word_t addr);
        tab_kind[i] = kind;
        tab_a[i]    = a;
        tab_b[i]    = b;
        tab_addr[i] = addr;
    endtask

    task automatic load_table();
        set_entry(0,  K_ADDU,  16'd5,      16'd7,      32'h100);
        set_entry(1,  K_SUBU,  16'd3,      16'd10,     32'h104);
        set_entry(2,  K_AND,   16'h0f0f,   16'h00ff,   32'h108);
        set_entry(3,  K_OR,    16'h1200,   16'h0034,   32'h10c);
        set_entry(4,  K_SLT,   16'hfffb,   16'd3,      32'h110);
        set_entry(5,  K_SLT,   16'd7,      16'hfffe,   32'h114);
        set_entry(6,  K_ADDI,  16'd100,    16'hffff,   32'h118);
        set_entry(7,  K_ORI,   16'h0001,   16'h8000,   32'h11c);
        set_entry(8,  K_LWUSE, 16'h0021,   16'd0,      32'h120);
        set_entry(9,  K_BEQ,   16'd9,      16'd9,      32'h124);
        set_entry(10, K_BEQ,   16'd9,      16'd4,      32'h128);
        set_entry(11, K_BNE,   16'd6,      16'd6,      32'h12c);
        set_entry(12, K_BNE,   16'd6,      16'd2,      32'h130);
        set_entry(13, K_J,     16'd11,     16'd12,     32'h134);
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic build_program();
        word_t x;
        word_t y;
        word_t adr;
        logic  taken;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            entry_first[i] = exp_addr.size();
            x   = sext16(tab_a[i]);
            y   = sext16(tab_b[i]);
            adr = tab_addr[i];
            prog.push_back(enc_i(`MIPS_OP_ADDI, 0, 1, tab_a[i]));
            case (tab_kind[i])
                K_LWUSE: begin
                    prog.push_back(enc_i(`MIPS_OP_SW, 0, 1, adr[15:0]));
                    prog.push_back(enc_i(`MIPS_OP_LW, 0, 4, adr[15:0]));
                    prog.push_back(enc_r(`MIPS_FN_ADDU, 4, 4, 3));
                    prog.push_back(enc_i(`MIPS_OP_SW, 0, 3, adr[15:0]));
                    expect_store(adr, x);
                    expect_store(adr, x + x);
                end
                K_BEQ, K_BNE: begin
                    prog.push_back(enc_i(`MIPS_OP_ADDI, 0, 2, tab_b[i]));
                    if (tab_kind[i] == K_BEQ) begin
                        prog.push_back(enc_i(`MIPS_OP_BEQ, 1, 2, 16'd1));
                        taken = (x == y);
                    end else begin
                        prog.push_back(enc_i(`MIPS_OP_BNE, 1, 2, 16'd1));
                        taken = (x != y);
                    end
                    // Guarded store, skipped when taken
                    prog.push_back(enc_i(`MIPS_OP_SW, 0, 1, adr[15:0]));
                    prog.push_back(enc_i(`MIPS_OP_SW, 0, 2, adr[15:0]));
                    if (!taken) begin
                        expect_store(adr, x);
                    end
                    expect_store(adr, y);
                end
                K_J: begin
                    prog.push_back(enc_j(word_t'((prog.size() + 2) * 4)));
                    prog.push_back(enc_i(`MIPS_OP_SW, 0, 1, adr[15:0]));
                    prog.push_back(enc_i(`MIPS_OP_ADDI, 0, 2, tab_b[i]));
                    prog.push_back(enc_i(`MIPS_OP_SW, 0, 2, adr[15:0]));
                    expect_store(adr, y);
                end
                default: begin
                    prog.push_back(enc_i(`MIPS_OP_ADDI, 0, 2, tab_b[i]));
                    if (tab_kind[i] == K_ADDI) begin
                        prog.push_back(enc_i(`MIPS_OP_ADDI, 1, 3, tab_b[i]));
                    end else if (tab_kind[i] == K_ORI) begin
                        prog.push_back(enc_i(`MIPS_OP_ORI, 1, 3, tab_b[i]));
                    end else begin
                        prog.push_back(enc_r(funct_of(tab_kind[i]), 1, 2, 3));
                    end
                    prog.push_back(enc_i(`MIPS_OP_SW, 0, 3, adr[15:0]));
                    expect_store(adr, ref_value(tab_kind[i], tab_a[i], tab_b[i]));
                end
            endcase
            entry_count[i] = exp_addr.size() - entry_first[i];
        end
        // Park the core on a jump to itself
        prog.push_back(enc_j(word_t'(prog.size() * 4)));
        for (int k = 0; k < IMEM_DEPTH; k++) begin
            cache0.imem[k] = (k < prog.size()) ? prog[k] : '0;
        end
    endtask

    task automatic reset_dut();
        rst <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (dcache_ren !== 1'b0 || dcache_wen !== 1'b0) begin
            $display("** Error %0t: cache request active after reset", $time);
            error_count++;
        end
        if ({icache_addr, 2'b00} !== `MIPS_RESET_PC) begin
            $display("** Error %0t: fetch address %h after reset", $time, {icache_addr, 2'b00});
            error_count++;
        end
        @(posedge clk);
    endtask

    task automatic check_entry(input int run, input int i);
        int    idx;
        logic  ok;
        word_t got_addr;
        word_t got_data;
        ok = 1'b1;
        for (int k = 0; k < entry_count[i]; k++) begin
            idx      = entry_first[i] + k;
            got_addr = cache0.log_addr[idx];
            got_data = cache0.log_data[idx];
            if (got_addr != exp_addr[idx] || got_data != exp_data[idx]) begin
                $display("** Error %0t: run %0d entry %0d %s store %0d got %h at %h, exp %h at %h",
                         $time, run, i, kind_name(tab_kind[i]), k,
                         got_data, got_addr, exp_data[idx], exp_addr[idx]);
                ok = 1'b0;
                error_count++;
            end
        end
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("run %0d entry %0d %s: %s", run, i, kind_name(tab_kind[i]), ok ? "ok" : "FAIL");
    endtask

    task automatic run_program(input int run, input logic with_stalls);
        int cycles;
        int limit;
        stall_en <= 1'b0;
        reset_dut();
        stall_en <= with_stalls;
        limit  = 8 * prog.size() + 200;
        cycles = 0;
        while (cache0.log_addr.size() < exp_addr.size() && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (cache0.log_addr.size() < exp_addr.size()) begin
            $display("run %0d timed out after %0d cycles with %0d of %0d stores written",
                     run, cycles, cache0.log_addr.size(), exp_addr.size());
            timed_out = 1'b1;
        end else begin
            repeat (DRAIN_CYCLES) @(negedge clk);
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                check_entry(run, i);
            end
            if (cache0.log_addr.size() != exp_addr.size()) begin
                $display("run %0d wrote %0d stores but only %0d were expected",
                         run, cache0.log_addr.size(), exp_addr.size());
                error_count++;
            end
            @(posedge clk);
            stall_en <= 1'b0;
        end
    endtask

    initial begin
        rst         = 1'b1;
        stall_en    = 1'b0;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        timed_out   = 1'b0;
        load_table();
        build_program();
        run_program(0, 1'b0);
        // Same program under random back-pressure
        if (!timed_out) begin
            run_program(1, 1'b1);
        end
        $display("%0d entry checks, %0d passed, %0d failed, %0d errors",
                 pass_count + fail_count, pass_count, fail_count, error_count);
        if (!timed_out && error_count == 0 && fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+.
mips_pkg.sv
pc_counter.sv
stall_ctrl.sv
mips_decoder.sv
reg_file.sv
alu.sv
forward_unit.sv
mips_pipeline.sv
tb_cache_model.sv
tb_mips_pipeline.sv

//--- Bender.yml
package:
  name: mips_pipeline

export_include_dirs:
  - .

sources:
  - mips_pkg.sv
  - pc_counter.sv
  - stall_ctrl.sv
  - mips_decoder.sv
  - reg_file.sv
  - alu.sv
  - forward_unit.sv
  - mips_pipeline.sv
  - target: test
    files:
      - tb_cache_model.sv
      - tb_mips_pipeline.sv
